/* src/lm80c_pkg.sv */
package lm80c_pkg;

	typedef logic [15:0] addr_t;    // Z80 address
	typedef logic [7:0]  byte_t;    // Data byte
	typedef logic [5:0]  colour_t;  // One VGA colour channel
	typedef logic [15:0] sample_t;  // DAC input word

	// CPU bus, strobes already active high
	// dout is the byte the CPU drives on writes
	typedef struct packed {
		addr_t addr;
		byte_t dout;
		logic  wr;
		logic  rd;
		logic  iorq;
		logic  mreq;
		logic  m1;
	} cpu_bus_t;

	typedef struct packed {
		logic pio_sel;
		logic ctc_sel;
		logic sio_sel;
		logic vdp_sel;
		logic psg_sel;
		logic vdp_csr_n;  // VDP read strobe, low active
		logic vdp_csw_n;  // VDP write strobe, low active
		logic psg_bdir;
		logic psg_bc;
	} io_ctrl_t;

	typedef struct packed {
		byte_t ctc;  // Also the interrupt vector
		byte_t vdp;
		byte_t psg;
	} periph_rd_t;

	// ROM loader port
	typedef struct packed {
		logic  loading;
		logic  wr;     // One byte per high cycle
		addr_t addr;
		byte_t data;
	} loader_t;

	typedef struct packed {
		colour_t r;
		colour_t g;
		colour_t b;
	} rgb_t;

	// I/O map by upper address nibble
	localparam logic [3:0] IO_PIO = 4'd0;
	localparam logic [3:0] IO_CTC = 4'd1;
	localparam logic [3:0] IO_SIO = 4'd2;
	localparam logic [3:0] IO_VDP = 4'd3;
	localparam logic [3:0] IO_PSG = 4'd4;
	localparam byte_t      LED_PORT = 8'd255;  // Fictional LED port

	localparam addr_t RAM_LO = 16'd32768;  // Writable window
	localparam addr_t RAM_HI = 16'd49151;

	// NTSC timing in VDP enable ticks
	localparam int unsigned H_TOTAL     = 685;
	localparam int unsigned V_TOTAL     = 263;
	localparam int unsigned H_SYNC      = 60;
	localparam int unsigned V_SYNC      = 8;
	localparam int unsigned H_ACTIVE_LO = 100;
	localparam int unsigned H_ACTIVE_HI = 600;
	localparam int unsigned STRIPE_W    = 32;

endpackage

/* src/clock_enables.sv */
`timescale 1ns/1ps

module clock_enables #(
	parameter int CPU_DIV = 6
) (
	input  logic ram_clock,
	input  logic RESET,
	output logic cpu_ena_o,  // Paces PSG and CTC
	output logic vdp_ena_o   // Paces video timing
);
	localparam int CW = (CPU_DIV > 1) ? $clog2(CPU_DIV) : 1;

	logic [CW-1:0] cpu_cnt;  // Modulo CPU_DIV
	logic [2:0]    vdp_cnt;  // Free running

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_cnt <= '0;
			vdp_cnt <= '0;
		end else begin
			if (cpu_cnt == CW'(CPU_DIV - 1))
				cpu_cnt <= '0;  // Wrap
			else
				cpu_cnt <= cpu_cnt + 1'b1;
			vdp_cnt <= vdp_cnt + 3'd1;
		end
	end

	// Counters sit at 0 right after reset, so both fire at once
	assign cpu_ena_o = (cpu_cnt == '0);
	assign vdp_ena_o = vdp_cnt inside {3'd0, 3'd2, 3'd4, 3'd6};  // Every other clock

endmodule

/* src/system_bus.sv */
`timescale 1ns/1ps

module system_bus (
	input  logic                  ram_clock,
	input  logic                  RESET,
	input  lm80c_pkg::cpu_bus_t   bus_i,
	input  lm80c_pkg::periph_rd_t periph_i,
	input  lm80c_pkg::byte_t      mem_rdata_i,
	output lm80c_pkg::io_ctrl_t   io_o,
	output lm80c_pkg::byte_t      cpu_din_o,
	output logic                  led_o
);
	import lm80c_pkg::*;

	logic       io_cycle;   // I/O but not memory
	logic [3:0] nibble;
	io_ctrl_t   io_next;
	logic       led_sel;    // Registered like the other selects
	byte_t      led_latch;

	assign io_cycle = bus_i.iorq & ~bus_i.mreq;
	assign nibble   = bus_i.addr[7:4];

	// Decode from the live bus, registered below
	always_comb begin
		io_next.pio_sel   = io_cycle & (nibble == IO_PIO);
		io_next.ctc_sel   = io_cycle & (nibble == IO_CTC);
		io_next.sio_sel   = io_cycle & (nibble == IO_SIO);
		io_next.vdp_sel   = io_cycle & (nibble == IO_VDP);
		io_next.psg_sel   = io_cycle & (nibble == IO_PSG);
		io_next.vdp_csr_n = ~(io_next.vdp_sel & bus_i.rd);
		io_next.vdp_csw_n = ~(io_next.vdp_sel & bus_i.wr);
		io_next.psg_bdir  = io_next.psg_sel & bus_i.wr;       // Write to PSG
		io_next.psg_bc    = io_next.psg_sel & ~bus_i.addr[0]; // Even port latches address
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			io_o    <= '{vdp_csr_n: 1'b1, vdp_csw_n: 1'b1, default: 1'b0};
			led_sel <= 1'b0;
		end else begin
			io_o    <= io_next;
			led_sel <= io_cycle & (bus_i.addr[7:0] == LED_PORT);  // Full byte match
		end
	end

	// LED port latch
	always_ff @(posedge ram_clock) begin
		if (RESET)
			led_latch <= '0;
		else if (led_sel & bus_i.wr)
			led_latch <= bus_i.dout;
	end

	assign led_o = |led_latch;  // Lit on any non-zero value

	// CPU read byte, selects are one cycle old here
	always_ff @(posedge ram_clock) begin
		if (bus_i.rd) begin
			if (io_o.pio_sel)
				cpu_din_o <= '0;           // No PIO fitted
			else if (io_o.ctc_sel)
				cpu_din_o <= periph_i.ctc;
			else if (io_o.sio_sel)
				cpu_din_o <= '0;           // No SIO either
			else if (io_o.vdp_sel)
				cpu_din_o <= periph_i.vdp;
			else if (io_o.psg_sel)
				cpu_din_o <= periph_i.psg;
			else if (led_sel)
				cpu_din_o <= led_latch;
			else
				cpu_din_o <= mem_rdata_i;  // Memory cycle
		end else if (bus_i.iorq & bus_i.m1) begin
			// Interrupt acknowledge, CTC supplies the vector
			cpu_din_o <= periph_i.ctc;
		end
	end

endmodule

/* src/system_memory.sv */
`timescale 1ns/1ps

module system_memory #(
	parameter int RAM_AW = 16
) (
	input  logic                ram_clock,
	input  lm80c_pkg::cpu_bus_t bus_i,
	input  lm80c_pkg::loader_t  load_i,
	output lm80c_pkg::byte_t    rdata_o
);
	import lm80c_pkg::*;

	logic [RAM_AW-1:0] ram_addr;
	byte_t             ram_din;
	logic              ram_we;
	logic              in_window;  // CPU address inside writable RAM

	byte_t mem [2**RAM_AW];

	assign in_window = (bus_i.addr >= RAM_LO) && (bus_i.addr <= RAM_HI);

	// Port owner is picked and registered here
	always_ff @(posedge ram_clock) begin
		if (load_i.loading) begin
			// Loader may write anywhere, ROM included
			ram_addr <= load_i.addr[RAM_AW-1:0];
			ram_din  <= load_i.data;
			ram_we   <= load_i.wr;
		end else begin
			ram_addr <= bus_i.addr[RAM_AW-1:0];
			ram_din  <= bus_i.dout;
			ram_we   <= bus_i.wr & bus_i.mreq & in_window;  // ROM half stays intact
		end
	end

	// Synchronous byte RAM, read returns old data on a write
	always_ff @(posedge ram_clock) begin
		if (ram_we)
			mem[ram_addr] <= ram_din;
		rdata_o <= mem[ram_addr];
	end

endmodule

/* src/test_pattern.sv */
`timescale 1ns/1ps

module test_pattern (
	input  logic            ram_clock,
	input  logic            RESET,
	input  logic            vdp_ena_i,
	output logic            hsync_o,
	output logic            vsync_o,
	output lm80c_pkg::rgb_t rgb_o
);
	import lm80c_pkg::*;

	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	logic [HW-1:0] hcnt;
	logic [VW-1:0] vcnt;
	logic [HW-1:0] stripe;  // Colour bar index
	logic          blank;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (vdp_ena_i) begin
			if (hcnt == HW'(H_TOTAL - 1)) begin
				hcnt <= '0;  // End of line
				if (vcnt == VW'(V_TOTAL - 1))
					vcnt <= '0;  // End of frame
				else
					vcnt <= vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// Syncs low at the start of line and frame
	assign hsync_o = (hcnt >= HW'(H_SYNC));
	assign vsync_o = (vcnt >= VW'(V_SYNC));

	assign blank = (vcnt < VW'(V_SYNC)) || (hcnt < HW'(H_ACTIVE_LO)) ||
		(hcnt > HW'(H_ACTIVE_HI));

	// Wraps below H_ACTIVE_LO but blank hides that
	assign stripe = (hcnt - HW'(H_ACTIVE_LO)) / HW'(STRIPE_W);

	always_comb begin
		rgb_o = '0;
		if (!blank) begin
			rgb_o.r = {stripe[0], 5'b0};  // Only the MSB of each channel
			rgb_o.g = {stripe[1], 5'b0};
			rgb_o.b = {stripe[2], 5'b0};
		end
	end

endmodule

/* src/audio_dac.sv */
`timescale 1ns/1ps

module audio_dac (
	input  logic             ram_clock,
	input  logic             RESET,
	input  lm80c_pkg::byte_t chan_a_i,
	input  lm80c_pkg::byte_t chan_b_i,
	input  lm80c_pkg::byte_t chan_c_i,
	output logic             audio_o
);
	import lm80c_pkg::*;

	localparam int SW = $bits(sample_t);

	logic [9:0]  chan_sum;  // Max 765, fits 10 bits
	sample_t     sample;
	logic [SW:0] acc;       // Top bit is the carry out

	assign chan_sum = 10'(chan_a_i) + 10'(chan_b_i) + 10'(chan_c_i);
	assign sample   = {chan_sum, 6'b0};  // Scale up to full DAC range

	// First-order sigma-delta
	// carry is dropped back out before each add
	always_ff @(posedge ram_clock) begin
		if (RESET)
			acc <= '0;
		else
			acc <= {1'b0, acc[SW-1:0]} + {1'b0, sample};
	end

	// Ones density tracks sample / 2^16
	assign audio_o = acc[SW];

endmodule

/* src/lm80c_core.sv */
`timescale 1ns/1ps

module lm80c_core #(
	parameter int CPU_DIV = 6,   // CPU enable period in clocks
	parameter int RAM_AW  = 16   // On-chip RAM address bits
) (
	input  logic                  ram_clock,
	input  logic                  RESET,
	input  lm80c_pkg::cpu_bus_t   bus_i,
	input  lm80c_pkg::periph_rd_t periph_i,
	input  lm80c_pkg::loader_t    load_i,
	input  logic                  boot_done_i,
	input  logic                  reset_key_i,
	input  lm80c_pkg::byte_t      chan_a_i,
	input  lm80c_pkg::byte_t      chan_b_i,
	input  lm80c_pkg::byte_t      chan_c_i,
	output lm80c_pkg::io_ctrl_t   io_o,
	output lm80c_pkg::byte_t      cpu_din_o,
	output logic                  cpu_ena_o,
	output logic                  cpu_reset_o,
	output logic                  cpu_wait_o,
	output logic                  led_o,
	output logic                  hsync_o,
	output logic                  vsync_o,
	output lm80c_pkg::rgb_t       rgb_o,
	output logic                  audio_o
);
	import lm80c_pkg::*;

	logic  vdp_ena;    // Video tick
	byte_t mem_rdata;  // RAM to read mux

	// CPU held in reset until boot is done or while the key is down
	assign cpu_reset_o = ~boot_done_i | reset_key_i;
	// Stalled during boot and any ROM load
	assign cpu_wait_o  = ~boot_done_i | load_i.loading;

	clock_enables #(.CPU_DIV(CPU_DIV)) u_clock_enables (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cpu_ena_o (cpu_ena_o),
		.vdp_ena_o (vdp_ena)
	);

	system_bus u_system_bus (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.bus_i       (bus_i),
		.periph_i    (periph_i),
		.mem_rdata_i (mem_rdata),
		.io_o        (io_o),
		.cpu_din_o   (cpu_din_o),
		.led_o       (led_o)
	);

	system_memory #(.RAM_AW(RAM_AW)) u_system_memory (
		.ram_clock (ram_clock),
		.bus_i     (bus_i),
		.load_i    (load_i),
		.rdata_o   (mem_rdata)
	);

	test_pattern u_test_pattern (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.vdp_ena_i (vdp_ena),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o),
		.rgb_o     (rgb_o)
	);

	audio_dac u_audio_dac (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.chan_a_i  (chan_a_i),
		.chan_b_i  (chan_b_i),
		.chan_c_i  (chan_c_i),
		.audio_o   (audio_o)
	);

endmodule

/* sim/lm80c_tb.sv */
`timescale 1ns/1ps

module lm80c_tb;
	import lm80c_pkg::*;

	localparam int CPU_PERIOD = 6;                  // CPU enable period in clocks
	localparam int LINE_CLKS  = 2 * H_TOTAL;        // VDP tick every other clock
	localparam int FRAME_CLKS = V_TOTAL * LINE_CLKS;

	logic       ram_clock;
	logic       RESET;
	cpu_bus_t   bus;
	periph_rd_t periph;
	loader_t    load;
	logic       boot_done;
	logic       reset_key;
	byte_t      chan_a;
	byte_t      chan_b;
	byte_t      chan_c;
	io_ctrl_t   io;
	byte_t      cpu_din;
	logic       cpu_ena;
	logic       cpu_reset;
	logic       cpu_wait;
	logic       led;
	logic       hsync;
	logic       vsync;
	rgb_t       rgb;
	logic       audio;

	byte_t       model_mem [65536];  // RAM mirror
	byte_t       model_led;          // LED latch mirror
	addr_t       loaded [$];         // Addresses with known contents
	logic [31:0] rng;

	lm80c_core #(
		.CPU_DIV (CPU_PERIOD),
		.RAM_AW  (16)
	) dut_i (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.bus_i       (bus),
		.periph_i    (periph),
		.load_i      (load),
		.boot_done_i (boot_done),
		.reset_key_i (reset_key),
		.chan_a_i    (chan_a),
		.chan_b_i    (chan_b),
		.chan_c_i    (chan_c),
		.io_o        (io),
		.cpu_din_o   (cpu_din),
		.cpu_ena_o   (cpu_ena),
		.cpu_reset_o (cpu_reset),
		.cpu_wait_o  (cpu_wait),
		.led_o       (led),
		.hsync_o     (hsync),
		.vsync_o     (vsync),
		.rgb_o       (rgb),
		.audio_o     (audio)
	);

	initial ram_clock = 1'b0;
	always #50 ram_clock = ~ram_clock;  // 100 ns period

	function automatic logic [31:0] rand_word();
		rng ^= rng << 13;  // xorshift32
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic cpu_bus_t mk_bus(addr_t a, byte_t d, logic w, logic r, logic io_c,
		logic mr, logic m);
		return '{addr: a, dout: d, wr: w, rd: r, iorq: io_c, mreq: mr, m1: m};
	endfunction

	// Expected chip controls for a held bus
	function automatic io_ctrl_t expected_io(cpu_bus_t b);
		io_ctrl_t e;
		e           = '0;
		e.vdp_csr_n = 1'b1;  // Idle strobes are high
		e.vdp_csw_n = 1'b1;
		if (b.iorq && !b.mreq) begin
			case (b.addr[7:4])
				IO_PIO: e.pio_sel = 1'b1;
				IO_CTC: e.ctc_sel = 1'b1;
				IO_SIO: e.sio_sel = 1'b1;
				IO_VDP: begin
					e.vdp_sel   = 1'b1;
					e.vdp_csr_n = !b.rd;
					e.vdp_csw_n = !b.wr;
				end
				IO_PSG: begin
					e.psg_sel  = 1'b1;
					e.psg_bdir = b.wr;
					e.psg_bc   = !b.addr[0];  // Even port is the address latch
				end
				default: e.pio_sel = 1'b0;  // LED port and unused nibbles
			endcase
		end
		return e;
	endfunction

	// Expected CPU read byte
	function automatic byte_t expected_din(cpu_bus_t b);
		if (!b.rd && b.iorq && b.m1)
			return periph.ctc;  // Interrupt vector
		if (b.iorq && !b.mreq) begin
			if (b.addr[7:0] == LED_PORT)
				return model_led;
			case (b.addr[7:4])
				IO_CTC:  return periph.ctc;
				IO_VDP:  return periph.vdp;
				IO_PSG:  return periph.psg;
				default: return 8'h00;  // PIO and SIO
			endcase
		end
		return model_mem[b.addr];
	endfunction

	// Colour bars on a visible line
	function automatic rgb_t bar_colour(int unsigned h);
		rgb_t        c;
		int unsigned bar;
		c = '0;
		if (h >= H_ACTIVE_LO && h <= H_ACTIVE_HI) begin
			bar    = (h - H_ACTIVE_LO) / STRIPE_W;
			c.r[5] = bar[0];  // MSB only
			c.g[5] = bar[1];
			c.b[5] = bar[2];
		end
		return c;
	endfunction

	function automatic void model_write(cpu_bus_t b);
		if (b.iorq && !b.mreq && b.addr[7:0] == LED_PORT)
			model_led = b.dout;
		else if (b.mreq && b.addr >= RAM_LO && b.addr <= RAM_HI)
			model_mem[b.addr] = b.dout;  // ROM half ignored
	endfunction

	task automatic fail_stop();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
			fail_stop();
		end
	endtask

	task automatic timed_out(input string what);
		$display("Timeout while waiting for %s", what);
		fail_stop();
	endtask

	// Hold one bus operation for 4 cycles, then compare
	task automatic bus_cycle(input cpu_bus_t b);
		bus = b;
		repeat (4) @(negedge ram_clock);
		check("io_o", io, expected_io(b));
		if (b.rd || (b.iorq && b.m1))
			check("cpu_din_o", cpu_din, expected_din(b));
		if (b.wr)
			model_write(b);
		check("led_o", led, model_led != 8'h00);
		bus = '0;
		@(negedge ram_clock);  // Idle gap
	endtask

	initial begin : stimulus
		addr_t       a;
		byte_t       d;
		int unsigned cnt;
		int unsigned ones;
		int unsigned exp_ones;
		logic        prev;

		RESET     = 1'b1;
		bus       = '0;
		periph    = '0;
		load      = '0;
		boot_done = 1'b0;
		reset_key = 1'b0;
		chan_a    = '0;
		chan_b    = '0;
		chan_c    = '0;
		model_led = '0;
		rng       = 32'h40b7a455;
		repeat (5) @(negedge ram_clock);
		check("io_o", io, expected_io('0));  // Reset values
		check("led_o", led, 1'b0);
		check("cpu_reset_o", cpu_reset, 1'b1);
		RESET = 1'b0;
		check("cpu_wait_o", cpu_wait, 1'b1);  // Boot not done yet

		// CPU enable pulses once every CPU_PERIOD clocks
		cnt = 0;
		while (!cpu_ena) begin
			@(negedge ram_clock);
			cnt++;
			if (cnt > CPU_PERIOD)
				timed_out("a CPU enable pulse");
		end
		for (int i = 1; i <= 2 * CPU_PERIOD; i++) begin
			@(negedge ram_clock);
			check("cpu_ena_o", cpu_ena, (i % CPU_PERIOD) == 0);
		end

		// ROM load after boot so only loading stalls the CPU
		boot_done    = 1'b1;
		load.loading = 1'b1;
		for (int i = 0; i < 64; i++) begin
			a = 16'(rand_word());
			if (i % 2 == 0)
				a = {2'b10, a[13:0]};  // Half inside the RAM window
			d = 8'(rand_word());
			load.wr   = 1'b1;
			load.addr = a;
			load.data = d;
			model_mem[a] = d;
			loaded.push_back(a);
			@(negedge ram_clock);
			check("cpu_wait_o", cpu_wait, 1'b1);
		end
		load.wr = 1'b0;
		@(negedge ram_clock);
		check("cpu_wait_o", cpu_wait, 1'b1);
		load.loading = 1'b0;
		@(negedge ram_clock);
		check("cpu_wait_o", cpu_wait, 1'b0);
		check("cpu_reset_o", cpu_reset, 1'b0);
		reset_key = 1'b1;
		@(negedge ram_clock);
		check("cpu_reset_o", cpu_reset, 1'b1);
		reset_key = 1'b0;

		foreach (loaded[i])
			bus_cycle(mk_bus(loaded[i], 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
		foreach (loaded[i]) begin
			d = 8'(rand_word());
			bus_cycle(mk_bus(loaded[i], d, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
			bus_cycle(mk_bus(loaded[i], 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
		end

		// Peripheral nibbles 0 to 4
		for (int n = 0; n <= 4; n++) begin
			periph = 24'(rand_word());
			a = {8'(rand_word()), 4'(n), 4'(rand_word())};
			d = 8'(rand_word());
			bus_cycle(mk_bus(a, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
			bus_cycle(mk_bus(a, d, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
			bus_cycle(mk_bus(a ^ 16'h0001, d, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		end

		repeat (4) begin
			periph.ctc = 8'(rand_word());  // Interrupt acknowledge
			bus_cycle(mk_bus({8'(rand_word()), 8'h10}, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
		end

		for (int i = 0; i < 6; i++) begin
			d = (i == 3) ? 8'h00 : 8'(rand_word());  // One zero write turns the LED off
			a = {8'(rand_word()), LED_PORT};
			bus_cycle(mk_bus(a, d, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
			bus_cycle(mk_bus(a, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
		end

		// Vertical sync length first
		cnt = 0;
		do begin
			prev = vsync;
			@(negedge ram_clock);
			cnt++;
			if (cnt > 2 * FRAME_CLKS)
				timed_out("a falling vsync edge");
		end while (!(prev && !vsync));
		cnt = 0;
		do begin
			@(negedge ram_clock);
			cnt++;
			if (cnt > 2 * V_SYNC * LINE_CLKS)
				timed_out("vsync to rise again");
		end while (!vsync);
		check("vsync_o low clocks", cnt, V_SYNC * LINE_CLKS);

		// Next full line is visible
		cnt = 0;
		do begin
			prev = hsync;
			@(negedge ram_clock);
			cnt++;
			if (cnt > 2 * LINE_CLKS)
				timed_out("a falling hsync edge");
		end while (!(prev && !hsync));
		cnt = 0;
		do begin
			prev = hsync;
			@(negedge ram_clock);
			cnt++;
			if (!hsync)
				check("rgb_o", rgb, '0);  // Blanked during sync
			check("rgb_o", rgb, bar_colour((cnt / 2) % H_TOTAL));  // One tick per 2 clocks
			if (cnt > 2 * LINE_CLKS)
				timed_out("the next falling hsync edge");
		end while (!(prev && !hsync));
		check("hsync_o period", cnt, LINE_CLKS);

		// Audio ones density over one full accumulator wrap
		chan_a   = 8'(rand_word());
		chan_b   = 8'(rand_word());
		chan_c   = 8'(rand_word());
		exp_ones = (int'(chan_a) + int'(chan_b) + int'(chan_c)) * 64;
		repeat (4) @(negedge ram_clock);
		ones = 0;
		repeat (65536) begin
			@(negedge ram_clock);
			ones += audio;
		end
		if (ones + 1 < exp_ones || ones > exp_ones + 1)
			check("audio_o ones", ones, exp_ones);

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* compile.f */
src/lm80c_pkg.sv
src/clock_enables.sv
src/system_bus.sv
src/system_memory.sv
src/test_pattern.sv
src/audio_dac.sv
src/lm80c_core.sv
sim/lm80c_tb.sv

/* Bender.yml */
package:
  name: lm80c_core

sources:
  - files:
      - src/lm80c_pkg.sv
      - src/clock_enables.sv
      - src/system_bus.sv
      - src/system_memory.sv
      - src/test_pattern.sv
      - src/audio_dac.sv
      - src/lm80c_core.sv
  - target: test
    files:
      - sim/lm80c_tb.sv
